// File: compile.f
source/cgmii_pkg.sv
source/pcs_pkg.sv
source/block_classifier.sv
source/tx_state_machine.sv
source/block_scrambler.sv
source/pcs_tx_encoder.sv
test/pcs_tx_encoder_assertions.sv
test/pcs_tx_encoder_tb.sv

// File: Bender.yml
package:
  name: pcs_tx_encoder

sources:
  - files:
      - source/cgmii_pkg.sv
      - source/pcs_pkg.sv
      - source/block_classifier.sv
      - source/tx_state_machine.sv
      - source/block_scrambler.sv
      - source/pcs_tx_encoder.sv
  - target: test
    files:
      - test/pcs_tx_encoder_assertions.sv
      - test/pcs_tx_encoder_tb.sv

// File: test/pcs_tx_encoder_tb.sv
`timescale 1ns/10ps
////////////////////////////////////////
// testbench for the PCS transmit encoder
// reference model, scoreboard, directed and random tests
////////////////////////////////////////
module pcs_tx_encoder_tb;
	import cgmii_pkg::*;
	import pcs_pkg::*;

	localparam logic [SCRAMBLER_W-1:0] SEED = 58'h1A5_C3F0_1D96_B7E4;
	localparam cgmii_data_t IDLE_WORD = {8{CGMII_IDLE}};
	localparam block_type_t TERM_TYPES [8] = '{BT_T0, BT_T1, BT_T2, BT_T3,
		BT_T4, BT_T5, BT_T6, BT_T7};
	localparam int DRAIN_LIMIT = 40;

	logic         i_clock;
	logic         i_reset;
	logic         i_enable;
	cgmii_data_t  i_tx_data;
	cgmii_ctrl_t  i_tx_ctrl;
	logic         o_valid;
	coded_block_t o_tx_coded;

	coded_block_t           expected_q [$];
	tx_state_t              ref_state;
	logic [SCRAMBLER_W-1:0] ref_scr;
	logic [31:0]            lcg_state = 32'hf66d_302f;
	int errors = 0;
	int blocks_sent = 0;
	int blocks_seen = 0;
	int blocks_checked = 0;
	int tests_run = 0;
	int err_mark;
	int sent_mark;
	int seen_mark;

	pcs_tx_encoder #(.P_SCRAMBLE(1'b1), .P_SCRAMBLER_SEED(SEED)) dut_i
	(
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_enable   (i_enable),
		.i_tx_data  (i_tx_data),
		.i_tx_ctrl  (i_tx_ctrl),
		.o_valid    (o_valid),
		.o_tx_coded (o_tx_coded)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic cgmii_data_t random_word();
		return {lcg_next(), lcg_next()};
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic coded_block_t classify(input cgmii_data_t data, input cgmii_ctrl_t ctrl,
		output block_class_t cls);
		cgmii_char_t lane [8];
		pcs_char_t   code [8];
		logic [7:0]  ok;
		logic [55:0] body;
		for (int i = 0; i < 8; i++)
		begin
			lane[i] = cgmii_char_t'(data >> (8 * (7 - i)));
			ok[i]   = (lane[i] == CGMII_IDLE) || (lane[i] == CGMII_ERROR);
			code[i] = (lane[i] == CGMII_IDLE) ? PCS_IDLE : PCS_ERROR;
		end
		cls = CLASS_E;
		classify = ERROR_BLOCK;
		if (ctrl == 8'h00)
		begin
			cls = CLASS_D;
			classify = {SYNC_DATA, data};
		end
		else if (ctrl == 8'h80 && lane[0] == CGMII_START)
		begin
			cls = CLASS_S;
			classify = {SYNC_CTRL, BT_S, data[55:0]};
		end
		else if (ctrl == 8'h80 && (lane[0] == CGMII_SEQ || lane[0] == CGMII_FSIG))
		begin
			cls = CLASS_C;
			classify = {SYNC_CTRL, BT_ORDER, lane[1], lane[2], lane[3],
				(lane[0] == CGMII_SEQ) ? ORDER_SEQ : ORDER_SIG, 28'h0};
		end
		else if (ctrl == 8'hFF && (&ok))
		begin
			cls = CLASS_C;
			classify = {SYNC_CTRL, BT_CTRL, code[0], code[1], code[2], code[3],
				code[4], code[5], code[6], code[7]};
		end
		else
		begin
			for (int n = 0; n < 8; n++)
			begin
				if (ctrl == (8'hFF >> n) && lane[n] == CGMII_TERMINATE &&
					(ok >> (n + 1)) == (8'hFF >> (n + 1)))
				begin
					body = '0;
					for (int i = 0; i < n; i++)
					begin
						body[55 - 8 * i -: 8] = lane[i];
					end
					// last lane sits in the lowest code slot
					for (int i = 7; i > n; i--)
					begin
						body[7 * (7 - i) +: 7] = code[i];
					end
					cls = CLASS_T;
					classify = {SYNC_CTRL, TERM_TYPES[n], body};
				end
			end
		end
	endfunction

	function automatic tx_state_t next_state(input tx_state_t state, input block_class_t cls);
		case (state)
			TX_D: return (cls == CLASS_D) ? TX_D : (cls == CLASS_T) ? TX_T : TX_E;
			TX_E: return (cls == CLASS_C) ? TX_C : (cls == CLASS_D) ? TX_D :
				(cls == CLASS_T) ? TX_T : TX_E;
			default: return (cls == CLASS_C) ? TX_C : (cls == CLASS_S) ? TX_D : TX_E;
		endcase
	endfunction

	function automatic coded_block_t model_block(input cgmii_data_t data,
		input cgmii_ctrl_t ctrl);
		block_class_t   cls;
		coded_block_t   blk;
		block_payload_t scrambled;
		blk = classify(data, ctrl, cls);
		ref_state = next_state(ref_state, cls);
		if (ref_state == TX_E)
		begin
			blk = ERROR_BLOCK;
		end
		// taps at x^39 and x^58, payload bit 0 first
		for (int i = 0; i < BLOCK_PAYLOAD_W; i++)
		begin
			scrambled[i] = blk[i] ^ ref_scr[38] ^ ref_scr[57];
			ref_scr = {ref_scr[56:0], scrambled[i]};
		end
		return {blk[65:64], scrambled};
	endfunction

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////
	task automatic send_word(input cgmii_data_t data, input cgmii_ctrl_t ctrl);
		@(posedge i_clock);
		#1;
		i_enable = 1'b1;
		i_tx_data = data;
		i_tx_ctrl = ctrl;
		expected_q.push_back(model_block(data, ctrl));
		blocks_sent++;
	endtask

	// enable low, junk on the data lines
	task automatic send_gap(input int cycles);
		repeat (cycles)
		begin
			@(posedge i_clock);
			#1;
			i_enable = 1'b0;
			i_tx_data = random_word();
			i_tx_ctrl = 8'h5A;
		end
	endtask

	// Tn word, trailing lanes idle or a random idle and error blend
	function automatic cgmii_data_t term_word(input int n, input bit mix);
		cgmii_data_t word;
		logic [31:0] r;
		word = random_word();
		word[63 - 8 * n -: 8] = CGMII_TERMINATE;
		for (int i = n + 1; i < 8; i++)
		begin
			r = lcg_next();
			word[63 - 8 * i -: 8] = (mix && r[4]) ? CGMII_ERROR : CGMII_IDLE;
		end
		return word;
	endfunction

	task automatic send_frame(input int n, input bit mix);
		cgmii_data_t word;
		word = random_word();
		word[63:56] = CGMII_START;
		send_word(word, 8'h80);
		send_word(random_word(), 8'h00);
		send_word(random_word(), 8'h00);
		send_word(term_word(n, mix), 8'hFF >> n);
		send_word(IDLE_WORD, 8'hFF);
	endtask

	task automatic send_ordered(input cgmii_char_t kind);
		cgmii_data_t word;
		word = random_word();
		word[63:56] = kind;
		send_word(word, 8'h80);
	endtask

	task automatic start_test();
		err_mark = errors;
		sent_mark = blocks_sent;
		seen_mark = blocks_seen;
	endtask

	task automatic finish_test(input string name);
		int waited;
		send_gap(1);
		waited = 0;
		while (expected_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(negedge i_clock);
			waited++;
		end
		assert (expected_q.size() == 0)
		else
		begin
			$display("timeout: %0d blocks never left the DUT in test %0s",
				expected_q.size(), name);
			errors++;
			expected_q.delete();
		end
		assert (blocks_seen - seen_mark == blocks_sent - sent_mark)
		else
		begin
			$display("block count wrong in test %0s: sent %0d, got %0d", name,
				blocks_sent - sent_mark, blocks_seen - seen_mark);
			errors++;
		end
		tests_run++;
		$display("test %0s done, %0d errors", name, errors - err_mark);
	endtask

	////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////
	initial
	begin : compare_blk
		coded_block_t expected;
		forever
		begin
			@(negedge i_clock);
			if (o_valid === 1'b1)
			begin
				blocks_seen++;
				assert (expected_q.size() != 0)
				else
				begin
					$display("o_valid high with no block expected at %0t", $time);
					errors++;
				end
				if (expected_q.size() != 0)
				begin
					expected = expected_q.pop_front();
					blocks_checked++;
					assert (o_tx_coded === expected)
					else
					begin
						$display("MISMATCH o_tx_coded expected %h actual %h", expected, o_tx_coded);
						errors++;
					end
				end
			end
		end
	end

	initial
	begin : main_blk
		logic [31:0] pick;
		cgmii_data_t word;
		i_reset = 1'b1;
		i_enable = 1'b0;
		i_tx_data = '0;
		i_tx_ctrl = 8'hFF;
		ref_state = TX_INIT;
		ref_scr = SEED;
		repeat (4) @(posedge i_clock);
		#1;
		i_reset = 1'b0;

		start_test();
		repeat (8) send_word(IDLE_WORD, 8'hFF);
		finish_test("idle stream");

		start_test();
		for (int n = 0; n < 8; n++)
		begin
			send_frame(n, 1'b0);
		end
		finish_test("frames T0 to T7");

		start_test();
		for (int n = 0; n < 8; n++)
		begin
			send_frame(n, 1'b1);
		end
		finish_test("mixed terminate tails");

		start_test();
		send_ordered(CGMII_SEQ);
		send_word(IDLE_WORD, 8'hFF);
		send_ordered(CGMII_FSIG);
		send_ordered(CGMII_SEQ);
		finish_test("ordered sets");

		// D after idle, S in a frame, odd control, T with no frame
		start_test();
		send_word(IDLE_WORD, 8'hFF);
		send_word(random_word(), 8'h00);
		send_word(IDLE_WORD, 8'hFF);
		word = random_word();
		word[63:56] = CGMII_START;
		send_word(word, 8'h80);
		send_word(random_word(), 8'h00);
		send_word(word, 8'h80);
		send_word(random_word(), 8'h00);
		send_word(term_word(3, 1'b0), 8'h1F);
		send_word(IDLE_WORD, 8'hFF);
		send_word(random_word(), 8'h3C);
		send_word(IDLE_WORD, 8'hFF);
		send_word(term_word(5, 1'b0), 8'h07);
		send_word(IDLE_WORD, 8'hFF);
		finish_test("illegal orders");

		start_test();
		for (int k = 0; k < 300; k++)
		begin
			pick = lcg_next();
			word = random_word();
			case (pick[2:0])
				3'd0, 3'd1: send_word(IDLE_WORD, 8'hFF);
				3'd2:
				begin
					word[63:56] = CGMII_START;
					send_word(word, 8'h80);
				end
				3'd3, 3'd4: send_word(word, 8'h00);
				3'd5: send_word(term_word(pick[10:8], pick[11]), 8'hFF >> pick[10:8]);
				3'd6: send_ordered(pick[12] ? CGMII_SEQ : CGMII_FSIG);
				default: send_word(word, pick[23:16]);
			endcase
			send_gap((pick[14:13] == 2'b11) ? int'(pick[16:15]) + 1 : 0);
		end
		finish_test("random words");

		$display("tests %0d, blocks checked %0d, errors %0d", tests_run, blocks_checked, errors);
		if (errors == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: test/pcs_tx_encoder_assertions.sv
`timescale 1ns/10ps
////////////////////////////////////////
// protocol checks for the transmit FSM
// and the scrambler, attached by bind
////////////////////////////////////////
module pcs_tx_encoder_assertions
(
	input logic                  i_clock,
	input logic                  i_reset,
	input logic                  i_in_valid,
	input logic                  i_out_valid,
	input pcs_pkg::coded_block_t i_out_block
);
	import pcs_pkg::*;

	// quiet right after reset
	assert property (@(posedge i_clock) $fell(i_reset) |-> !i_out_valid)
	else $error("valid high in the first cycle after reset");

	assert property (@(posedge i_clock) disable iff (i_reset)
		i_out_valid |-> (i_out_block[65:64] == SYNC_DATA || i_out_block[65:64] == SYNC_CTRL))
	else $error("illegal sync header %b", i_out_block[65:64]);

	// one cycle of latency per stage
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_out_valid == $past(i_in_valid))
	else $error("valid out of step with the stage input");

endmodule

bind tx_state_machine pcs_tx_encoder_assertions fsm_checks_i
(
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_in_valid  (i_valid),
	.i_out_valid (o_valid),
	.i_out_block (o_coded_block)
);

bind block_scrambler pcs_tx_encoder_assertions scrambler_checks_i
(
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_in_valid  (i_valid),
	.i_out_valid (o_valid),
	.i_out_block (o_tx_coded)
);

// File: source/pcs_tx_encoder.sv
`timescale 1ns/10ps
////////////////////////////////////////
// 10GBASE-R PCS transmit encoder
// classifier, transmit FSM and scrambler in a row
////////////////////////////////////////
module pcs_tx_encoder
#(
	parameter bit                           P_SCRAMBLE       = 1'b1,
	parameter logic [pcs_pkg::SCRAMBLER_W-1:0] P_SCRAMBLER_SEED = '1
)
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  cgmii_pkg::cgmii_data_t i_tx_data,
	input  cgmii_pkg::cgmii_ctrl_t i_tx_ctrl,
	output logic                   o_valid,
	output pcs_pkg::coded_block_t  o_tx_coded
);
	import pcs_pkg::*;

	logic         class_valid;
	block_class_t block_class;
	coded_block_t coded_block;
	logic         fsm_valid;
	coded_block_t fsm_block;

	block_classifier classifier_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_tx_data     (i_tx_data),
		.i_tx_ctrl     (i_tx_ctrl),
		.o_valid       (class_valid),
		.o_block_class (block_class),
		.o_coded_block (coded_block)
	);

	tx_state_machine fsm_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (class_valid),
		.i_block_class (block_class),
		.i_coded_block (coded_block),
		.o_valid       (fsm_valid),
		.o_coded_block (fsm_block)
	);

	block_scrambler
	#(
		.P_SCRAMBLE       (P_SCRAMBLE),
		.P_SCRAMBLER_SEED (P_SCRAMBLER_SEED)
	)
	scrambler_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (fsm_valid),
		.i_coded_block (fsm_block),
		.o_valid       (o_valid),
		.o_tx_coded    (o_tx_coded)
	);

endmodule

// File: source/block_scrambler.sv
`timescale 1ns/10ps
////////////////////////////////////////
// block scrambler
// self-synchronizing x^58 + x^39 + 1 on the payload,
// sync header passes unscrambled
////////////////////////////////////////
module block_scrambler
#(
	parameter bit                           P_SCRAMBLE       = 1'b1,
	parameter logic [pcs_pkg::SCRAMBLER_W-1:0] P_SCRAMBLER_SEED = '1
)
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_valid,
	input  pcs_pkg::coded_block_t i_coded_block,
	output logic                  o_valid,
	output pcs_pkg::coded_block_t o_tx_coded
);
	import pcs_pkg::*;

	logic [SCRAMBLER_W-1:0] scr_state;
	logic [SCRAMBLER_W-1:0] scr_next;
	block_payload_t         payload_in;
	block_payload_t         payload_scr;

	assign payload_in = i_coded_block[BLOCK_PAYLOAD_W-1:0];

	// whole payload in one cycle, bit 0 first
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 0; i < BLOCK_PAYLOAD_W; i++)
		begin
			payload_scr[i] = payload_in[i] ^ scr_next[38] ^ scr_next[57];
			scr_next       = {scr_next[SCRAMBLER_W-2:0], payload_scr[i]};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			scr_state <= P_SCRAMBLER_SEED;
			o_valid   <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
			begin
				scr_state <= scr_next;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			o_tx_coded <= {i_coded_block[CODED_BLOCK_W-1 -: SYNC_W],
				P_SCRAMBLE ? payload_scr : payload_in};
		end
	end

endmodule

// File: source/tx_state_machine.sv
`timescale 1ns/10ps
////////////////////////////////////////
// transmit FSM
// checks the order of block classes and puts
// the error block in place of illegal blocks
////////////////////////////////////////
module tx_state_machine
(
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_valid,
	input  pcs_pkg::block_class_t i_block_class,
	input  pcs_pkg::coded_block_t i_coded_block,
	output logic                  o_valid,
	output pcs_pkg::coded_block_t o_coded_block
);
	import pcs_pkg::*;

	tx_state_t state;
	tx_state_t state_next;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////
	always_comb
	begin
		state_next = state;
		case (state)
			// idle, after a terminate or before the first block
			TX_INIT, TX_C, TX_T:
			begin
				case (i_block_class)
					CLASS_C: state_next = TX_C;
					CLASS_S: state_next = TX_D;
					default: state_next = TX_E;
				endcase
			end
			// inside a frame
			TX_D:
			begin
				case (i_block_class)
					CLASS_D: state_next = TX_D;
					CLASS_T: state_next = TX_T;
					default: state_next = TX_E;
				endcase
			end
			// leave error on the next C, D or T
			TX_E:
			begin
				case (i_block_class)
					CLASS_C: state_next = TX_C;
					CLASS_D: state_next = TX_D;
					CLASS_T: state_next = TX_T;
					default: state_next = TX_E;
				endcase
			end
			default: state_next = TX_E;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state   <= TX_INIT;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
			begin
				state <= state_next;
			end
		end
	end

	// output block
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			o_coded_block <= (state_next == TX_E) ? ERROR_BLOCK : i_coded_block;
		end
	end

endmodule

// File: source/block_classifier.sv
`timescale 1ns/10ps
////////////////////////////////////////
// block classifier
// registers one CGMII word, sorts it into a block
// class and builds the unscrambled coded block
////////////////////////////////////////
module block_classifier
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  cgmii_pkg::cgmii_data_t i_tx_data,
	input  cgmii_pkg::cgmii_ctrl_t i_tx_ctrl,
	output logic                   o_valid,
	output pcs_pkg::block_class_t  o_block_class,
	output pcs_pkg::coded_block_t  o_coded_block
);
	import cgmii_pkg::*;
	import pcs_pkg::*;

	// payload after the block type field
	localparam int BODY_W = BLOCK_PAYLOAD_W - 8;

	cgmii_data_t            tx_data;
	cgmii_ctrl_t            tx_ctrl;
	logic                   valid_q;

	cgmii_char_t            chars [CGMII_LANES];
	logic [CGMII_LANES-1:0] char_ok;
	logic [BODY_W-1:0]      code_word;
	logic                   t_hit;
	logic [2:0]             t_index;
	block_type_t            t_type;
	logic [BODY_W-1:0]      t_body;

	////////////////////////////////////////
	// input register
	////////////////////////////////////////
	// control held at all ones in reset so no legal class shows
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			tx_ctrl <= CTRL_ALL;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= i_enable;
			if (i_enable)
			begin
				tx_ctrl <= i_tx_ctrl;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_enable)
		begin
			tx_data <= i_tx_data;
		end
	end

	////////////////////////////////////////
	// per byte character mapping
	////////////////////////////////////////
	// code of byte i lands at the same place in C and T blocks
	always_comb
	begin
		for (int i = 0; i < CGMII_LANES; i++)
		begin
			chars[i]   = tx_data[CGMII_DATA_W-1-CGMII_CHAR_W*i -: CGMII_CHAR_W];
			char_ok[i] = (chars[i] == CGMII_IDLE) || (chars[i] == CGMII_ERROR);
			code_word[BODY_W-1-PCS_CHAR_W*i -: PCS_CHAR_W] =
				(chars[i] == CGMII_IDLE) ? PCS_IDLE : PCS_ERROR;
		end
	end

	// terminate search, Tn has n data lanes then the terminate
	always_comb
	begin
		logic [CGMII_LANES-1:0] later;
		t_hit   = 1'b0;
		t_index = '0;
		later   = '0;
		for (int n = 0; n < CGMII_LANES; n++)
		begin
			// lanes after the terminate, idle or error in any mix
			later = CTRL_ALL << (n + 1);
			if (tx_ctrl == (CTRL_ALL >> n) && chars[n] == CGMII_TERMINATE &&
				(char_ok & later) == later)
			begin
				t_hit   = 1'b1;
				t_index = 3'(n);
			end
		end
	end

	always_comb
	begin
		case (t_index)
			3'd0: t_type = BT_T0;
			3'd1: t_type = BT_T1;
			3'd2: t_type = BT_T2;
			3'd3: t_type = BT_T3;
			3'd4: t_type = BT_T4;
			3'd5: t_type = BT_T5;
			3'd6: t_type = BT_T6;
			default: t_type = BT_T7;
		endcase
	end

	// data bytes on top, codes below, zero pad in the gap
	assign t_body = (tx_data[CGMII_DATA_W-1 -: BODY_W] & ~({BODY_W{1'b1}} >> (8 * t_index)))
		| (code_word & ({BODY_W{1'b1}} >> (7 + 7 * t_index)));

	////////////////////////////////////////
	// class and block assembly
	////////////////////////////////////////
	always_comb
	begin
		o_block_class = CLASS_E;
		o_coded_block = ERROR_BLOCK;
		if (tx_ctrl == CTRL_DATA)
		begin
			o_block_class = CLASS_D;
			o_coded_block = {SYNC_DATA, tx_data};
		end
		else if (tx_ctrl == CTRL_LEAD && chars[0] == CGMII_START)
		begin
			o_block_class = CLASS_S;
			o_coded_block = {SYNC_CTRL, BT_S, tx_data[BODY_W-1:0]};
		end
		else if (tx_ctrl == CTRL_LEAD && (chars[0] == CGMII_SEQ || chars[0] == CGMII_FSIG))
		begin
			o_block_class = CLASS_C;
			o_coded_block = {SYNC_CTRL, BT_ORDER, tx_data[BODY_W-1 -: 24],
				(chars[0] == CGMII_SEQ) ? ORDER_SEQ : ORDER_SIG, 28'h0};
		end
		else if (tx_ctrl == CTRL_ALL && (&char_ok))
		begin
			o_block_class = CLASS_C;
			o_coded_block = {SYNC_CTRL, BT_CTRL, code_word};
		end
		else if (t_hit)
		begin
			o_block_class = CLASS_T;
			o_coded_block = {SYNC_CTRL, t_type, t_body};
		end
	end

	assign o_valid = valid_q;

endmodule

// File: source/pcs_pkg.sv
////////////////////////////////////////
// 10GBASE-R PCS definitions
// coded block layout, block types, block classes
// and the transmit FSM states
////////////////////////////////////////
package pcs_pkg;

	localparam int SYNC_W          = 2;
	localparam int BLOCK_PAYLOAD_W = 64;
	localparam int CODED_BLOCK_W   = SYNC_W + BLOCK_PAYLOAD_W;
	localparam int PCS_CHAR_W      = 7;
	localparam int SCRAMBLER_W     = 58;

	// sync header on top, payload below
	typedef logic [CODED_BLOCK_W-1:0]   coded_block_t;
	typedef logic [BLOCK_PAYLOAD_W-1:0] block_payload_t;
	typedef logic [PCS_CHAR_W-1:0]      pcs_char_t;
	typedef logic [SYNC_W-1:0]          sync_header_t;
	typedef logic [7:0]                 block_type_t;
	typedef logic [3:0]                 order_code_t;

	localparam sync_header_t SYNC_DATA = 2'b01;
	localparam sync_header_t SYNC_CTRL = 2'b10;

	localparam pcs_char_t PCS_IDLE  = 7'h00;
	localparam pcs_char_t PCS_ERROR = 7'h1E;

	////////////////////////////////////////
	// block type field
	////////////////////////////////////////
	localparam block_type_t BT_CTRL  = 8'h1E;
	localparam block_type_t BT_S     = 8'h78;
	localparam block_type_t BT_ORDER = 8'h4B;
	localparam block_type_t BT_T0    = 8'h87;
	localparam block_type_t BT_T1    = 8'h99;
	localparam block_type_t BT_T2    = 8'hAA;
	localparam block_type_t BT_T3    = 8'hB4;
	localparam block_type_t BT_T4    = 8'hCC;
	localparam block_type_t BT_T5    = 8'hD2;
	localparam block_type_t BT_T6    = 8'hE1;
	localparam block_type_t BT_T7    = 8'hFF;

	// ordered set codes
	localparam order_code_t ORDER_SEQ = 4'h0;
	localparam order_code_t ORDER_SIG = 4'hF;

	// block classes seen by the transmit FSM
	typedef logic [2:0] block_class_t;
	localparam block_class_t CLASS_C = 3'd0;
	localparam block_class_t CLASS_S = 3'd1;
	localparam block_class_t CLASS_D = 3'd2;
	localparam block_class_t CLASS_T = 3'd3;
	localparam block_class_t CLASS_E = 3'd4;

	typedef enum logic [2:0] {TX_INIT, TX_C, TX_D, TX_T, TX_E} tx_state_t;

	// control block full of error codes
	localparam coded_block_t ERROR_BLOCK = {SYNC_CTRL, BT_CTRL, {8{PCS_ERROR}}};

endpackage

// File: source/cgmii_pkg.sv
////////////////////////////////////////
// CGMII definitions
// word widths, control patterns and character codes
////////////////////////////////////////
package cgmii_pkg;

	localparam int CGMII_DATA_W = 64;
	localparam int CGMII_CTRL_W = 8;
	localparam int CGMII_CHAR_W = 8;
	localparam int CGMII_LANES  = CGMII_DATA_W / CGMII_CHAR_W;

	// byte 0 sits in the top byte of the word
	typedef logic [CGMII_DATA_W-1:0] cgmii_data_t;

	// bit 7 flags byte 0
	typedef logic [CGMII_CTRL_W-1:0] cgmii_ctrl_t;

	typedef logic [CGMII_CHAR_W-1:0] cgmii_char_t;

	////////////////////////////////////////
	// control characters
	////////////////////////////////////////
	localparam cgmii_char_t CGMII_START     = 8'hFB;
	localparam cgmii_char_t CGMII_TERMINATE = 8'hFD;
	localparam cgmii_char_t CGMII_IDLE      = 8'h07;
	localparam cgmii_char_t CGMII_ERROR     = 8'hFE;
	localparam cgmii_char_t CGMII_SEQ       = 8'h9C;
	localparam cgmii_char_t CGMII_FSIG      = 8'h5C;

	////////////////////////////////////////
	// control bit patterns
	////////////////////////////////////////
	// all data lanes
	localparam cgmii_ctrl_t CTRL_DATA = 8'h00;
	// only byte 0 is control (start, ordered set)
	localparam cgmii_ctrl_t CTRL_LEAD = 8'h80;
	// all control lanes
	localparam cgmii_ctrl_t CTRL_ALL  = 8'hFF;

endpackage
